//--- cft_regs.f
common/cft_pkg.sv
reg_major/reg_counter.sv
reg_major/reg_major.sv
verilog/ibus_mux.sv
verilog/link_register.sv
verilog/cft_regs.sv
tb/cft_regs_tb.sv

//--- Makefile
# Verilator build and run for the CFT register unit

VERILATOR ?= verilator
TOP       ?= cft_regs_tb
FILELIST  ?= cft_regs.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/cft_regs_tb.sv
//////////////////////////////
// Testbench for the CFT register unit
// LFSR-driven strobes, a shadow model of the registers and L flag,
// and concurrent assertions that compare the DUT against the model
//////////////////////////////

`timescale 1ns/1ps

module cft_regs_tb;

   localparam int clk_period  = 10;
   localparam int n_ops       = 400;
   localparam int watchdog_ns = (n_ops + 20) * clk_period + 200;

   // DUT inputs
   logic               clk;
   logic               arst_n;
   cft_pkg::reg_ctrl_s ctrl [4];
   cft_pkg::cft_word_t ibus_in;
   logic               link_clear;
   logic               link_cpl;
   cft_pkg::fp_sel_s   fp_sel;

   // DUT outputs
   cft_pkg::cft_word_t ibus;
   cft_pkg::cft_word_t pc_q;
   cft_pkg::cft_word_t ac_q;
   logic               fz;
   logic               fn;
   logic               link;
   cft_pkg::cft_byte_t fpd;

   // Shadow model state and its expected outputs
   cft_pkg::cft_word_t m_regs [4];
   logic               m_link;
   cft_pkg::cft_word_t exp_ibus;
   cft_pkg::cft_byte_t exp_fpd;
   cft_pkg::cft_word_t fp_word;
   logic               exp_wrap;

   int          errors;
   logic [31:0] lfsr;

   cft_regs cft_regs_i (
      .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .ibus_in(ibus_in),
      .link_clear(link_clear), .link_cpl(link_cpl), .fp_sel(fp_sel),
      .ibus(ibus), .pc_q(pc_q), .ac_q(ac_q), .fz(fz), .fn(fn),
      .link(link), .fpd(fpd)
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit, newest bit at the bottom
   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[14:0], lfsr[0]};
      end
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] exp,
                                  input logic [15:0] act);
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
   endtask

   // All strobes low, bus input and panel select untouched
   task automatic clear_strobes();
      for (int i = 0; i < 4; i++) begin
         ctrl[i] = '0;
      end
      link_clear = 1'b0;
      link_cpl   = 1'b0;
   endtask

   //////////////////////////////
   // Clock and shadow model
   //////////////////////////////

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   // Expected bus is the reading register or else the external word
   always_comb begin
      exp_ibus = ibus_in;
      for (int i = 0; i < 4; i++) begin
         if (ctrl[i].read) begin
            exp_ibus = m_regs[i];
         end
      end
   end

   always_comb begin
      fp_word = m_regs[fp_sel.idx];
      if (!fp_sel.en) begin
         exp_fpd = '0;
      end else if (fp_sel.high) begin
         exp_fpd = fp_word[15:8];
      end else begin
         exp_fpd = fp_word[7:0];
      end
   end

   // AC about to roll over in either direction
   // Write beats inc and inc beats dec
   always_comb begin
      if (ctrl[cft_pkg::ac].write) begin
         exp_wrap = 1'b0;
      end else if (ctrl[cft_pkg::ac].inc) begin
         exp_wrap = (m_regs[cft_pkg::ac] == 16'hffff);
      end else if (ctrl[cft_pkg::ac].dec) begin
         exp_wrap = (m_regs[cft_pkg::ac] == 16'h0000);
      end else begin
         exp_wrap = 1'b0;
      end
   end

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 4; i++) begin
            m_regs[i] <= '0;
         end
         m_link <= 1'b0;
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (ctrl[i].write) begin
               m_regs[i] <= exp_ibus;
            end else if (ctrl[i].inc) begin
               m_regs[i] <= m_regs[i] + 16'd1;
            end else if (ctrl[i].dec && i != int'(cft_pkg::pc)) begin
               m_regs[i] <= m_regs[i] - 16'd1;
            end
         end
         m_link <= link_clear ? 1'b0 : (m_link ^ link_cpl ^ exp_wrap);
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // State in the first cycle out of reset
   reset_pc_a: assert property (@(posedge clk) $rose(arst_n) |-> pc_q == '0)
      else report_mismatch("reset_pc", 16'h0000, $sampled(pc_q));
   reset_ac_a: assert property (@(posedge clk) $rose(arst_n) |-> ac_q == '0)
      else report_mismatch("reset_ac", 16'h0000, $sampled(ac_q));
   reset_flags_a: assert property (@(posedge clk) $rose(arst_n) |-> {link, fz, fn} == 3'b010)
      else report_mismatch("reset_flags", 16'h0002, 16'($sampled({link, fz, fn})));

   bus_a: assert property (@(posedge clk) disable iff (!arst_n) ibus == exp_ibus)
      else report_mismatch("bus_value", $sampled(exp_ibus), $sampled(ibus));
   pc_a: assert property (@(posedge clk) disable iff (!arst_n) pc_q == m_regs[cft_pkg::pc])
      else report_mismatch("pc_model", $sampled(m_regs[cft_pkg::pc]), $sampled(pc_q));
   ac_a: assert property (@(posedge clk) disable iff (!arst_n) ac_q == m_regs[cft_pkg::ac])
      else report_mismatch("ac_model", $sampled(m_regs[cft_pkg::ac]), $sampled(ac_q));

   // PC ignores dec
   pc_dec_a: assert property (@(posedge clk) disable iff (!arst_n)
      ctrl[cft_pkg::pc].dec |=> pc_q == $past(pc_q))
      else report_mismatch("pc_dec_ignored", $sampled(m_regs[cft_pkg::pc]), $sampled(pc_q));

   fz_a: assert property (@(posedge clk) disable iff (!arst_n) fz == (ac_q == '0))
      else report_mismatch("fz_flag", 16'($sampled(ac_q) == '0), 16'($sampled(fz)));
   fn_a: assert property (@(posedge clk) disable iff (!arst_n) fn == ac_q[15])
      else report_mismatch("fn_flag", 16'($sampled(ac_q[15])), 16'($sampled(fn)));

   link_a: assert property (@(posedge clk) disable iff (!arst_n) link == m_link)
      else report_mismatch("link_model", 16'($sampled(m_link)), 16'($sampled(link)));
   link_wrap_a: assert property (@(posedge clk) disable iff (!arst_n)
      (exp_wrap && !link_cpl && !link_clear) |=> link != $past(link))
      else report_mismatch("link_wrap", 16'($sampled(m_link)), 16'($sampled(link)));
   // Wrap and complement in one cycle leave L alone
   link_cancel_a: assert property (@(posedge clk) disable iff (!arst_n)
      (exp_wrap && link_cpl && !link_clear) |=> link == $past(link))
      else report_mismatch("link_cancel", 16'($sampled(m_link)), 16'($sampled(link)));
   link_clear_a: assert property (@(posedge clk) disable iff (!arst_n) link_clear |=> !link)
      else report_mismatch("link_clear", 16'h0000, 16'($sampled(link)));

   fpd_a: assert property (@(posedge clk) disable iff (!arst_n) fpd == exp_fpd)
      else report_mismatch("front_panel", 16'($sampled(exp_fpd)), 16'($sampled(fpd)));

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial begin : stimulus
      logic [15:0] bits;
      logic [15:0] sel;
      logic [15:0] val;
      int          op;
      errors  = 0;
      lfsr    = 32'h2f82_a969;
      arst_n  = 1'b0;
      ibus_in = '0;
      fp_sel  = '0;
      clear_strobes();
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      for (int n = 0; n < n_ops; n++) begin
         @(negedge clk);
         clear_strobes();
         take_bits(16, val);
         ibus_in = val;
         take_bits(3, bits);
         op = int'(bits[2:0]) % 6;
         // Half of the single-register ops land on AC to reach its wraps
         take_bits(3, sel);
         if (sel[2]) begin
            sel[1:0] = 2'(cft_pkg::ac);
         end
         case (op)
            0: begin
               // External write, often a terminal value
               take_bits(2, bits);
               if (bits[1:0] == 2'd0) begin
                  ibus_in = 16'hffff;
               end else if (bits[1:0] == 2'd1) begin
                  ibus_in = 16'h0000;
               end
               ctrl[sel[1:0]].write = 1'b1;
            end
            1: begin
               take_bits(4, bits);
               ctrl[bits[3:2]].read  = 1'b1;
               ctrl[bits[1:0]].write = 1'b1;
            end
            2: begin
               take_bits(1, bits);
               ctrl[sel[1:0]].inc = 1'b1;
               link_cpl = bits[0];
            end
            3: begin
               take_bits(1, bits);
               ctrl[sel[1:0]].dec = 1'b1;
               link_cpl = bits[0];
            end
            4: begin
               take_bits(2, bits);
               link_clear = bits[1];
               link_cpl   = bits[0];
            end
            default: begin
               // Panel select, sometimes with a bus read
               take_bits(7, bits);
               fp_sel.en   = bits[6];
               fp_sel.idx  = cft_pkg::reg_idx_e'(bits[5:4]);
               fp_sel.high = bits[3];
               if (bits[2]) begin
                  ctrl[bits[1:0]].read = 1'b1;
               end
            end
         endcase
      end
      @(negedge clk);
      clear_strobes();
      repeat (2) @(posedge clk);
      @(negedge clk);
      $display("Errors: %0d failed checks over %0d operations", errors, n_ops);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      #(watchdog_ns);
      $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
      $display("Test FAILED");
      $finish;
   end

endmodule

//--- verilog/cft_regs.sv
//////////////////////////////
// Register unit of the CFT processor
// Four major registers on one internal bus, plus the L flag
// Strobes come from the sequencer, one cycle each
//////////////////////////////

`timescale 1ns/1ps

module cft_regs (
   input  logic               clk,
   input  logic               arst_n,
   input  cft_pkg::reg_ctrl_s ctrl [4],
   input  cft_pkg::cft_word_t ibus_in,
   input  logic               link_clear,
   input  logic               link_cpl,
   input  cft_pkg::fp_sel_s   fp_sel,
   output cft_pkg::cft_word_t ibus,
   output cft_pkg::cft_word_t pc_q,
   output cft_pkg::cft_word_t ac_q,
   output logic               fz,
   output logic               fn,
   output logic               link,
   output cft_pkg::cft_byte_t fpd
);

   // Register words, indexed like ctrl
   cft_pkg::cft_word_t regs_q [4];

   // Read strobes gathered for the mux
   logic [3:0] rd;

   // AC wrap towards the L flag
   logic ac_wrap;

   assign rd[cft_pkg::pc] = ctrl[cft_pkg::pc].read;
   assign rd[cft_pkg::dr] = ctrl[cft_pkg::dr].read;
   assign rd[cft_pkg::ac] = ctrl[cft_pkg::ac].read;
   assign rd[cft_pkg::sp] = ctrl[cft_pkg::sp].read;

   //////////////////////////////
   // Major registers
   //////////////////////////////

   // Program counter, count up only
   reg_major #(.can_dec(1'b0), .has_flags(1'b0)) pc_reg (
      .clk(clk), .arst_n(arst_n), .ctrl(ctrl[cft_pkg::pc]), .bus(ibus),
      .q(regs_q[cft_pkg::pc]), .fz(), .fn(), .wrap()
   );

   // Data register
   reg_major #(.can_dec(1'b1), .has_flags(1'b0)) dr_reg (
      .clk(clk), .arst_n(arst_n), .ctrl(ctrl[cft_pkg::dr]), .bus(ibus),
      .q(regs_q[cft_pkg::dr]), .fz(), .fn(), .wrap()
   );

   // Accumulator with flags and wrap
   reg_major #(.can_dec(1'b1), .has_flags(1'b1)) ac_reg (
      .clk(clk), .arst_n(arst_n), .ctrl(ctrl[cft_pkg::ac]), .bus(ibus),
      .q(regs_q[cft_pkg::ac]), .fz(fz), .fn(fn), .wrap(ac_wrap)
   );

   // Stack pointer
   reg_major #(.can_dec(1'b1), .has_flags(1'b0)) sp_reg (
      .clk(clk), .arst_n(arst_n), .ctrl(ctrl[cft_pkg::sp]), .bus(ibus),
      .q(regs_q[cft_pkg::sp]), .fz(), .fn(), .wrap()
   );

   assign pc_q = regs_q[cft_pkg::pc];
   assign ac_q = regs_q[cft_pkg::ac];

   //////////////////////////////
   // Bus, panel and L flag
   //////////////////////////////

   ibus_mux ibus_mux_i (
      .regs(regs_q), .rd(rd), .ibus_in(ibus_in), .fp_sel(fp_sel),
      .ibus(ibus), .fpd(fpd)
   );

   link_register link_i (
      .clk(clk), .arst_n(arst_n), .clear(link_clear), .cpl(link_cpl),
      .wrap(ac_wrap), .link(link)
   );

endmodule

//--- verilog/link_register.sv
//////////////////////////////
// L flag of the CFT
// Toggled by the AC wrap output or by an explicit complement
//////////////////////////////

`timescale 1ns/1ps

module link_register (
   input  logic clk,
   input  logic arst_n,
   input  logic clear,
   input  logic cpl,
   input  logic wrap,
   output logic link
);

   // Next value of the flag
   logic link_next;

   //////////////////////////////
   // Next state
   //////////////////////////////

   // Clear wins over any toggle
   // A complement and a wrap together cancel out
   always_comb begin
      if (clear) begin
         link_next = 1'b0;
      end else begin
         link_next = link ^ cpl ^ wrap;
      end
   end

   //////////////////////////////
   // Flag register
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         link <= 1'b0;
      end else begin
         link <= link_next;
      end
   end

endmodule

//--- verilog/ibus_mux.sv
//////////////////////////////
// Internal bus and front-panel multiplexer
// Replaces the tri-state drivers of the register boards
//////////////////////////////

`timescale 1ns/1ps

module ibus_mux (
   input  cft_pkg::cft_word_t regs [4],
   input  logic [3:0]         rd,
   input  cft_pkg::cft_word_t ibus_in,
   input  cft_pkg::fp_sel_s   fp_sel,
   output cft_pkg::cft_word_t ibus,
   output cft_pkg::cft_byte_t fpd
);

   // Word picked for the front panel, seen as bytes
   cft_pkg::cft_word_u fp_word;

   //////////////////////////////
   // Internal bus
   //////////////////////////////

   // OR of the enabled registers, as on a wired bus
   // External device drives the bus when nobody reads
   always_comb begin
      ibus = '0;
      for (int i = 0; i < 4; i++) begin
         if (rd[i]) begin
            ibus = ibus | regs[i];
         end
      end
      if (rd == '0) begin
         ibus = ibus_in;
      end
   end

   // Two readers would mix their words
   always_comb begin
      rd_onehot_a: assert ($onehot0(rd))
         else $error("ibus_mux: more than one read strobe high");
   end

   //////////////////////////////
   // Front panel
   //////////////////////////////

   assign fp_word.word = regs[fp_sel.idx];

   // Blank panel when not selected
   assign fpd = !fp_sel.en ? '0
              : fp_sel.high ? fp_word.bytes.hi
              : fp_word.bytes.lo;

endmodule

//--- reg_major/reg_major.sv
//////////////////////////////
// One major register of the CFT (PC, DR, AC or SP)
// can_dec drops the decrement path, has_flags adds FZ, FN and wrap
// Loads from the internal bus and hands its word to the bus mux
//////////////////////////////

`timescale 1ns/1ps

module reg_major #(
   parameter bit can_dec   = 1'b1,
   parameter bit has_flags = 1'b1
) (
   input  logic               clk,
   input  logic               arst_n,
   input  cft_pkg::reg_ctrl_s ctrl,
   input  cft_pkg::cft_word_t bus,
   output cft_pkg::cft_word_t q,
   output logic               fz,
   output logic               fn,
   output logic               wrap
);

   // Counter side of the strobes
   logic cnt_down;

   // Counter state and its terminal count
   cft_pkg::cft_word_t cnt_q;
   logic               cnt_wrap;

   //////////////////////////////
   // Storage
   //////////////////////////////

   // PC has no decrement, so its dec strobe goes nowhere
   assign cnt_down = can_dec ? ctrl.dec : 1'b0;

   reg_counter counter_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .load     (ctrl.write),
      .load_val (bus),
      .up       (ctrl.inc),
      .down     (cnt_down),
      .q        (cnt_q),
      .wrap     (cnt_wrap)
   );

   // Register output, used by the bus mux and front panel
   assign q = cnt_q;

   //////////////////////////////
   // Flags
   //////////////////////////////

   generate
      if (has_flags) begin : g_flags
         // Byte view of the register for the zero test
         cft_pkg::cft_word_u view;

         assign view.word = cnt_q;

         // Zero when both bytes are clear, like the two cascaded comparators
         assign fz = (view.bytes.hi == '0) && (view.bytes.lo == '0);

         // Sign bit is bit 15, top of the high byte
         assign fn = view.bytes.hi[7];

         // Toggle request for the L flag
         assign wrap = cnt_wrap;
      end else begin : g_no_flags
         assign fz   = 1'b0;
         assign fn   = 1'b0;
         assign wrap = 1'b0;
      end
   endgenerate

   // A bus access and a count never share a cycle
   bus_vs_count_a: assert property (@(posedge clk) disable iff (!arst_n)
      (ctrl.write || ctrl.read) |-> !(ctrl.inc || ctrl.dec))
      else $error("reg_major: bus access combined with inc or dec");

endmodule

//--- reg_major/reg_counter.sv
//////////////////////////////
// Up/down counter with parallel load
// Storage element of every major register
// wrap flags an up count from all ones or a down count from zero
//////////////////////////////

`timescale 1ns/1ps

module reg_counter (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              load,
   input  cft_pkg::cft_word_t load_val,
   input  logic              up,
   input  logic              down,
   output cft_pkg::cft_word_t q,
   output logic              wrap
);

   // Current count
   cft_pkg::cft_word_t count;

   // Terminal count in each direction
   logic at_top;
   logic at_bottom;

   //////////////////////////////
   // Count register
   //////////////////////////////

   // Load beats up, up beats down
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (load) begin
         count <= load_val;
      end else if (up) begin
         count <= count + 1'b1;
      end else if (down) begin
         count <= count - 1'b1;
      end
   end

   assign q = count;

   //////////////////////////////
   // Terminal count
   //////////////////////////////

   assign at_top    = (count == '1);
   assign at_bottom = (count == '0);

   // Like the chained carry and borrow of a '193 cascade
   // A load never reports a wrap
   assign wrap = !load && ((up && at_top) || (!up && down && at_bottom));

   // The sequencer must never ask for both directions at once
   up_down_excl_a: assert property (@(posedge clk) disable iff (!arst_n) !(up && down))
      else $error("reg_counter: up and down strobes high together");

endmodule

//--- common/cft_pkg.sv
//////////////////////////////
// Shared types for the CFT register unit
// Word, byte and strobe definitions used by every register block
// Referenced with cft_pkg:: scoped names
//////////////////////////////

package cft_pkg;

   //////////////////////////////
   // Data word
   //////////////////////////////

   // Width of the processor data word
   localparam int word_w = 16;

   // One bus or register word
   typedef logic [word_w-1:0] cft_word_t;

   // One front-panel byte
   typedef logic [word_w/2-1:0] cft_byte_t;

   // Byte view of a word, high byte first
   typedef struct packed {
      cft_byte_t hi;
      cft_byte_t lo;
   } cft_bytes_s;

   // Same word seen whole or as two bytes
   typedef union packed {
      cft_word_t  word;
      cft_bytes_s bytes;
   } cft_word_u;

   //////////////////////////////
   // Register selection and strobes
   //////////////////////////////

   // Major register index, also the ctrl array index
   typedef enum logic [1:0] {
      pc = 2'd0,
      dr = 2'd1,
      ac = 2'd2,
      sp = 2'd3
   } reg_idx_e;

   // Single-cycle strobes for one register
   typedef struct packed {
      logic read;
      logic write;
      logic inc;
      logic dec;
   } reg_ctrl_s;

   // Front-panel byte select
   typedef struct packed {
      logic     en;
      reg_idx_e idx;
      logic     high;
   } fp_sel_s;

endpackage
